//--- src/tlb_macros.svh
`ifndef TLB_MACROS_SVH
`define TLB_MACROS_SVH

// table geometry
`define TLB_NUM   16
`define TLB_IDX_W 4

// page-size codes as seen on the ps ports
`define TLB_PS_4K 6'd12
`define TLB_PS_4M 6'd21

// invalidate operation codes
`define INV_ALL0     5'd0
`define INV_ALL1     5'd1
`define INV_G1       5'd2
`define INV_G0       5'd3
`define INV_ASID     5'd4
`define INV_ASID_VA  5'd5
`define INV_GASID_VA 5'd6

`endif

//--- src/tlb_pkg.sv
`include "tlb_macros.svh"

package tlb_pkg;

    // virtual page-pair number, va[31:13]
    typedef logic [18:0] vppn_t;

    // address-space id
    typedef logic [9:0] asid_t;

    // physical page number
    typedef logic [19:0] ppn_t;

    // page-size code, 12 or 21
    typedef logic [5:0] ps_t;

    // privilege level
    typedef logic [1:0] plv_t;

    // memory access type
    typedef logic [1:0] mat_t;

    // entry index
    typedef logic [`TLB_IDX_W-1:0] idx_t;

    // invalidate operation
    typedef logic [4:0] inv_op_t;

    // one bit per entry
    typedef logic [`TLB_NUM-1:0] entry_vec_t;

endpackage

//--- src/tlb_array_if.sv
`timescale 1ns/1ns
`include "tlb_macros.svh"

interface tlb_array_if;

    // single-bit fields packed one bit per entry
    tlb_pkg::entry_vec_t e;
    tlb_pkg::entry_vec_t ps4m;
    tlb_pkg::entry_vec_t g;
    tlb_pkg::entry_vec_t d0;
    tlb_pkg::entry_vec_t v0;
    tlb_pkg::entry_vec_t d1;
    tlb_pkg::entry_vec_t v1;

    tlb_pkg::vppn_t vppn [`TLB_NUM];
    tlb_pkg::asid_t asid [`TLB_NUM];
    // even half
    tlb_pkg::ppn_t  ppn0 [`TLB_NUM];
    tlb_pkg::plv_t  plv0 [`TLB_NUM];
    tlb_pkg::mat_t  mat0 [`TLB_NUM];
    // odd half
    tlb_pkg::ppn_t  ppn1 [`TLB_NUM];
    tlb_pkg::plv_t  plv1 [`TLB_NUM];
    tlb_pkg::mat_t  mat1 [`TLB_NUM];

    modport store (
        output e, ps4m, vppn, asid, g,
        output ppn0, plv0, mat0, d0, v0,
        output ppn1, plv1, mat1, d1, v1
    );

    modport lookup (
        input e, ps4m, vppn, asid, g,
        input ppn0, plv0, mat0, d0, v0,
        input ppn1, plv1, mat1, d1, v1
    );

    modport inv (input e, g, asid, vppn);

endinterface

//--- src/tlb_storage.sv
`timescale 1ns/1ns
`include "tlb_macros.svh"

module tlb_storage (
    input  logic                clk,
    input  logic                rst,
    // write port
    input  logic                we,
    input  tlb_pkg::idx_t       w_index,
    input  logic                w_e,
    input  tlb_pkg::vppn_t      w_vppn,
    input  tlb_pkg::ps_t        w_ps,
    input  tlb_pkg::asid_t      w_asid,
    input  logic                w_g,
    input  tlb_pkg::ppn_t       w_ppn0,
    input  tlb_pkg::plv_t       w_plv0,
    input  tlb_pkg::mat_t       w_mat0,
    input  logic                w_d0,
    input  logic                w_v0,
    input  tlb_pkg::ppn_t       w_ppn1,
    input  tlb_pkg::plv_t       w_plv1,
    input  tlb_pkg::mat_t       w_mat1,
    input  logic                w_d1,
    input  logic                w_v1,
    // entries to drop this cycle
    input  tlb_pkg::entry_vec_t clr,
    // read port
    input  tlb_pkg::idx_t       r_index,
    output logic                r_e,
    output tlb_pkg::vppn_t      r_vppn,
    output tlb_pkg::ps_t        r_ps,
    output tlb_pkg::asid_t      r_asid,
    output logic                r_g,
    output tlb_pkg::ppn_t       r_ppn0,
    output tlb_pkg::plv_t       r_plv0,
    output tlb_pkg::mat_t       r_mat0,
    output logic                r_d0,
    output logic                r_v0,
    output tlb_pkg::ppn_t       r_ppn1,
    output tlb_pkg::plv_t       r_plv1,
    output tlb_pkg::mat_t       r_mat1,
    output logic                r_d1,
    output logic                r_v1,
    tlb_array_if.store          arr
);

    tlb_pkg::entry_vec_t e_q;
    tlb_pkg::entry_vec_t ps4m_q;
    tlb_pkg::entry_vec_t g_q;
    tlb_pkg::entry_vec_t d0_q;
    tlb_pkg::entry_vec_t v0_q;
    tlb_pkg::entry_vec_t d1_q;
    tlb_pkg::entry_vec_t v1_q;
    tlb_pkg::vppn_t      vppn_q [`TLB_NUM];
    tlb_pkg::asid_t      asid_q [`TLB_NUM];
    tlb_pkg::ppn_t       ppn0_q [`TLB_NUM];
    tlb_pkg::plv_t       plv0_q [`TLB_NUM];
    tlb_pkg::mat_t       mat0_q [`TLB_NUM];
    tlb_pkg::ppn_t       ppn1_q [`TLB_NUM];
    tlb_pkg::plv_t       plv1_q [`TLB_NUM];
    tlb_pkg::mat_t       mat1_q [`TLB_NUM];

    // exist bits, clear mask wins over a same-cycle write
    always_ff @(posedge clk) begin
        if (rst) begin
            e_q <= '0;
        end else begin
            for (int i = 0; i < `TLB_NUM; i++) begin
                if (clr[i]) begin
                    e_q[i] <= 1'b0;
                end else if (we && w_index == tlb_pkg::idx_t'(i)) begin
                    e_q[i] <= w_e;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ps4m_q <= '0;
            g_q    <= '0;
            d0_q   <= '0;
            v0_q   <= '0;
            d1_q   <= '0;
            v1_q   <= '0;
            for (int i = 0; i < `TLB_NUM; i++) begin
                vppn_q[i] <= '0;
                asid_q[i] <= '0;
                ppn0_q[i] <= '0;
                plv0_q[i] <= '0;
                mat0_q[i] <= '0;
                ppn1_q[i] <= '0;
                plv1_q[i] <= '0;
                mat1_q[i] <= '0;
            end
        end else if (we) begin
            // anything other than 21 is kept as 4 KB
            ps4m_q[w_index] <= (w_ps == `TLB_PS_4M);
            g_q[w_index]    <= w_g;
            d0_q[w_index]   <= w_d0;
            v0_q[w_index]   <= w_v0;
            d1_q[w_index]   <= w_d1;
            v1_q[w_index]   <= w_v1;
            vppn_q[w_index] <= w_vppn;
            asid_q[w_index] <= w_asid;
            ppn0_q[w_index] <= w_ppn0;
            plv0_q[w_index] <= w_plv0;
            mat0_q[w_index] <= w_mat0;
            ppn1_q[w_index] <= w_ppn1;
            plv1_q[w_index] <= w_plv1;
            mat1_q[w_index] <= w_mat1;
        end
    end

    // whole table out to the lookups and the invalidate decoder
    assign arr.e    = e_q;
    assign arr.ps4m = ps4m_q;
    assign arr.g    = g_q;
    assign arr.d0   = d0_q;
    assign arr.v0   = v0_q;
    assign arr.d1   = d1_q;
    assign arr.v1   = v1_q;
    assign arr.vppn = vppn_q;
    assign arr.asid = asid_q;
    assign arr.ppn0 = ppn0_q;
    assign arr.plv0 = plv0_q;
    assign arr.mat0 = mat0_q;
    assign arr.ppn1 = ppn1_q;
    assign arr.plv1 = plv1_q;
    assign arr.mat1 = mat1_q;

    assign r_e    = e_q[r_index];
    assign r_vppn = vppn_q[r_index];
    assign r_ps   = ps4m_q[r_index] ? `TLB_PS_4M : `TLB_PS_4K;
    assign r_asid = asid_q[r_index];
    assign r_g    = g_q[r_index];
    assign r_ppn0 = ppn0_q[r_index];
    assign r_plv0 = plv0_q[r_index];
    assign r_mat0 = mat0_q[r_index];
    assign r_d0   = d0_q[r_index];
    assign r_v0   = v0_q[r_index];
    assign r_ppn1 = ppn1_q[r_index];
    assign r_plv1 = plv1_q[r_index];
    assign r_mat1 = mat1_q[r_index];
    assign r_d1   = d1_q[r_index];
    assign r_v1   = v1_q[r_index];

endmodule

//--- src/tlb_inv_mask.sv
`timescale 1ns/1ns
`include "tlb_macros.svh"

module tlb_inv_mask (
    input  logic                invtlb_valid,
    input  tlb_pkg::inv_op_t    invtlb_op,
    input  tlb_pkg::asid_t      invtlb_asid,
    input  tlb_pkg::vppn_t      invtlb_va,
    tlb_array_if.inv            arr,
    output tlb_pkg::entry_vec_t clr
);

    tlb_pkg::entry_vec_t asid_eq;
    tlb_pkg::entry_vec_t va_eq;
    tlb_pkg::entry_vec_t rule;

    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            asid_eq[i] = (arr.asid[i] == invtlb_asid);
            // full vppn compare that ignores the page size
            va_eq[i]   = (arr.vppn[i] == invtlb_va);
        end
    end

    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            case (invtlb_op)
                `INV_ALL0, `INV_ALL1: begin
                    rule[i] = 1'b1;
                end
                `INV_G1: begin
                    rule[i] = arr.g[i];
                end
                `INV_G0: begin
                    rule[i] = !arr.g[i];
                end
                `INV_ASID: begin
                    rule[i] = !arr.g[i] && asid_eq[i];
                end
                `INV_ASID_VA: begin
                    rule[i] = !arr.g[i] && asid_eq[i] && va_eq[i];
                end
                `INV_GASID_VA: begin
                    rule[i] = (arr.g[i] || asid_eq[i]) && va_eq[i];
                end
                // reserved codes are a no-op
                default: begin
                    rule[i] = 1'b0;
                end
            endcase
        end
    end

    // dead entries hit by the rule are flagged too so a same-cycle
    // write to them cannot bring them back
    assign clr = invtlb_valid ? rule : '0;

endmodule

//--- src/tlb_lookup.sv
`timescale 1ns/1ns
`include "tlb_macros.svh"

module tlb_lookup (
    input  tlb_pkg::vppn_t vppn,
    input  logic           va_bit12,
    input  tlb_pkg::asid_t asid,
    tlb_array_if.lookup    arr,
    output logic           found,
    output tlb_pkg::idx_t  index,
    output tlb_pkg::ppn_t  ppn,
    output tlb_pkg::ps_t   ps,
    output tlb_pkg::plv_t  plv,
    output tlb_pkg::mat_t  mat,
    output logic           d,
    output logic           v
);

    tlb_pkg::entry_vec_t hit;
    logic                odd;

    // per-entry compare
    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            hit[i] = arr.e[i]
                && (vppn[18:9] == arr.vppn[i][18:9])
                && (arr.ps4m[i] || vppn[8:0] == arr.vppn[i][8:0])
                && (arr.g[i] || asid == arr.asid[i]);
        end
    end

    // lowest index wins, entry 0 when nothing hits
    always_comb begin
        index = '0;
        for (int i = `TLB_NUM - 1; i >= 0; i--) begin
            if (hit[i]) begin
                index = tlb_pkg::idx_t'(i);
            end
        end
    end

    assign found = |hit;

    // 4 MB pages split on va[21], which is vppn bit 8
    assign odd = arr.ps4m[index] ? vppn[8] : va_bit12;

    assign ps  = arr.ps4m[index] ? `TLB_PS_4M : `TLB_PS_4K;
    assign ppn = odd ? arr.ppn1[index] : arr.ppn0[index];
    assign plv = odd ? arr.plv1[index] : arr.plv0[index];
    assign mat = odd ? arr.mat1[index] : arr.mat0[index];
    assign d   = odd ? arr.d1[index] : arr.d0[index];
    assign v   = odd ? arr.v1[index] : arr.v0[index];

endmodule

//--- src/tlb.sv
`timescale 1ns/1ns

module tlb (
    input  logic             clk,
    input  logic             rst,
    // fetch lookup
    input  tlb_pkg::vppn_t   s0_vppn,
    input  logic             s0_va_bit12,
    input  tlb_pkg::asid_t   s0_asid,
    output logic             s0_found,
    output tlb_pkg::idx_t    s0_index,
    output tlb_pkg::ppn_t    s0_ppn,
    output tlb_pkg::ps_t     s0_ps,
    output tlb_pkg::plv_t    s0_plv,
    output tlb_pkg::mat_t    s0_mat,
    output logic             s0_d,
    output logic             s0_v,
    // load/store lookup
    input  tlb_pkg::vppn_t   s1_vppn,
    input  logic             s1_va_bit12,
    input  tlb_pkg::asid_t   s1_asid,
    output logic             s1_found,
    output tlb_pkg::idx_t    s1_index,
    output tlb_pkg::ppn_t    s1_ppn,
    output tlb_pkg::ps_t     s1_ps,
    output tlb_pkg::plv_t    s1_plv,
    output tlb_pkg::mat_t    s1_mat,
    output logic             s1_d,
    output logic             s1_v,
    // invalidate
    input  logic             invtlb_valid,
    input  tlb_pkg::inv_op_t invtlb_op,
    input  tlb_pkg::asid_t   invtlb_asid,
    input  tlb_pkg::vppn_t   invtlb_va,
    // write port
    input  logic             we,
    input  tlb_pkg::idx_t    w_index,
    input  logic             w_e,
    input  tlb_pkg::vppn_t   w_vppn,
    input  tlb_pkg::ps_t     w_ps,
    input  tlb_pkg::asid_t   w_asid,
    input  logic             w_g,
    input  tlb_pkg::ppn_t    w_ppn0,
    input  tlb_pkg::plv_t    w_plv0,
    input  tlb_pkg::mat_t    w_mat0,
    input  logic             w_d0,
    input  logic             w_v0,
    input  tlb_pkg::ppn_t    w_ppn1,
    input  tlb_pkg::plv_t    w_plv1,
    input  tlb_pkg::mat_t    w_mat1,
    input  logic             w_d1,
    input  logic             w_v1,
    // read port
    input  tlb_pkg::idx_t    r_index,
    output logic             r_e,
    output tlb_pkg::vppn_t   r_vppn,
    output tlb_pkg::ps_t     r_ps,
    output tlb_pkg::asid_t   r_asid,
    output logic             r_g,
    output tlb_pkg::ppn_t    r_ppn0,
    output tlb_pkg::plv_t    r_plv0,
    output tlb_pkg::mat_t    r_mat0,
    output logic             r_d0,
    output logic             r_v0,
    output tlb_pkg::ppn_t    r_ppn1,
    output tlb_pkg::plv_t    r_plv1,
    output tlb_pkg::mat_t    r_mat1,
    output logic             r_d1,
    output logic             r_v1
);

    tlb_pkg::entry_vec_t clr;

    tlb_array_if arr ();

    // port names match the top level one to one
    tlb_storage u_storage (
        .arr (arr.store),
        .*
    );

    tlb_inv_mask u_inv (
        .arr (arr.inv),
        .*
    );

    tlb_lookup u_fetch (
        .vppn     (s0_vppn),
        .va_bit12 (s0_va_bit12),
        .asid     (s0_asid),
        .arr      (arr.lookup),
        .found    (s0_found),
        .index    (s0_index),
        .ppn      (s0_ppn),
        .ps       (s0_ps),
        .plv      (s0_plv),
        .mat      (s0_mat),
        .d        (s0_d),
        .v        (s0_v)
    );

    tlb_lookup u_data (
        .vppn     (s1_vppn),
        .va_bit12 (s1_va_bit12),
        .asid     (s1_asid),
        .arr      (arr.lookup),
        .found    (s1_found),
        .index    (s1_index),
        .ppn      (s1_ppn),
        .ps       (s1_ps),
        .plv      (s1_plv),
        .mat      (s1_mat),
        .d        (s1_d),
        .v        (s1_v)
    );

endmodule

//--- test/tlb_assertions.sv
`timescale 1ns/1ns
`include "tlb_macros.svh"

module tlb_assertions (
    input logic          clk,
    input logic          rst,
    input logic          s0_found,
    input logic          s1_found,
    input tlb_pkg::ps_t  s0_ps,
    input tlb_pkg::ps_t  s1_ps,
    input logic          we,
    input logic          w_e,
    input tlb_pkg::idx_t w_index,
    input logic          invtlb_valid,
    input tlb_pkg::idx_t r_index,
    input logic          r_e
);

    int fail_count = 0;

    // table is empty while reset clears it and on the first cycle after
    reset_miss: assert property (@(posedge clk) rst |=> !s0_found && !s1_found)
        else begin
            fail_count++;
            $error("lookup reported a hit during or right after reset");
        end

    ps_code: assert property (@(posedge clk) disable iff (rst)
        (s0_ps == `TLB_PS_4K || s0_ps == `TLB_PS_4M)
        && (s1_ps == `TLB_PS_4K || s1_ps == `TLB_PS_4M))
        else begin
            fail_count++;
            $error("lookup page size is neither 12 nor 21");
        end

    write_sticks: assert property (@(posedge clk) disable iff (rst)
        we && w_e && !invtlb_valid |=> r_index != $past(w_index) || r_e)
        else begin
            fail_count++;
            $error("written entry does not exist one cycle after the write");
        end

endmodule

bind tlb tlb_assertions u_assert (.*);

//--- test/tb_tlb.sv
`timescale 1ns/1ns
`include "tlb_macros.svh"

module tb_tlb;

    typedef struct packed {
        tlb_pkg::ppn_t ppn;
        tlb_pkg::plv_t plv;
        tlb_pkg::mat_t mat;
        logic          d;
        logic          v;
    } half_t;

    typedef struct packed {
        logic           e;
        tlb_pkg::vppn_t vppn;
        logic           ps4m;
        tlb_pkg::asid_t asid;
        logic           g;
        half_t          h0;
        half_t          h1;
    } ent_t;

    typedef struct packed {
        logic          found;
        tlb_pkg::idx_t idx;
        tlb_pkg::ps_t  ps;
        half_t         h;
    } res_t;

    localparam int N_LOOK = 300;
    localparam int N_INV_LOOK = 16;
    // writes and invalidates take two cycles, reads and lookups one
    localparam int TEST_CYCLES = 10 + 20 + 48 + 64 + N_LOOK + 8 * (50 + N_INV_LOOK) + 56;

    logic clk, rst, we, w_e, w_g, w_d0, w_v0, w_d1, w_v1, invtlb_valid;
    logic s0_va_bit12, s1_va_bit12, s0_found, s1_found, s0_d, s0_v, s1_d, s1_v;
    logic r_e, r_g, r_d0, r_v0, r_d1, r_v1;
    tlb_pkg::vppn_t s0_vppn, s1_vppn, invtlb_va, w_vppn, r_vppn;
    tlb_pkg::asid_t s0_asid, s1_asid, invtlb_asid, w_asid, r_asid;
    tlb_pkg::idx_t s0_index, s1_index, w_index, r_index;
    tlb_pkg::ppn_t s0_ppn, s1_ppn, w_ppn0, w_ppn1, r_ppn0, r_ppn1;
    tlb_pkg::ps_t s0_ps, s1_ps, w_ps, r_ps;
    tlb_pkg::plv_t s0_plv, s1_plv, w_plv0, w_plv1, r_plv0, r_plv1;
    tlb_pkg::mat_t s0_mat, s1_mat, w_mat0, w_mat1, r_mat0, r_mat1;
    tlb_pkg::inv_op_t invtlb_op;

    ent_t shadow [`TLB_NUM];
    int errors = 0;
    int checks = 0;
    int test_no = 0;
    int err_mark = 0;

    tlb UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #((TEST_CYCLES + 200) * 20);
        $display("timeout: the tests did not finish in the expected time");
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        test_no++;
        $display("test %0d %s: %0d errors", test_no, name, errors - err_mark);
        err_mark = errors;
    endtask

    function automatic ent_t rand_entry();
        ent_t x;
        x.e = ($urandom % 8) != 0;
        x.vppn = tlb_pkg::vppn_t'($urandom);
        // small pools so that entries collide and lookups hit
        x.vppn[18:9] = 10'($urandom % 4);
        x.vppn[7:0] = 8'($urandom % 4);
        x.ps4m = 1'b0;
        x.asid = tlb_pkg::asid_t'($urandom % 4);
        x.g = ($urandom % 4) == 0;
        x.h0 = half_t'($urandom);
        x.h1 = half_t'($urandom);
        return x;
    endfunction

    // any code but 21 is stored as 4 KB
    function automatic tlb_pkg::ps_t rand_ps();
        return ($urandom % 3 == 0) ? `TLB_PS_4M : tlb_pkg::ps_t'($urandom);
    endfunction

    function automatic void rand_query(output tlb_pkg::vppn_t va, output tlb_pkg::asid_t asid);
        ent_t x;
        x = shadow[tlb_pkg::idx_t'($urandom)];
        va = tlb_pkg::vppn_t'($urandom);
        asid = ($urandom % 2 != 0) ? x.asid : tlb_pkg::asid_t'($urandom % 4);
        if ($urandom % 5 != 0) begin
            va[18:9] = x.vppn[18:9];
            // bit 8 stays random and picks the half of a 4 MB page
            va[7:0] = x.vppn[7:0];
        end
    endfunction

    function automatic tlb_pkg::entry_vec_t inv_ref(input tlb_pkg::inv_op_t op,
                                                    input tlb_pkg::asid_t asid,
                                                    input tlb_pkg::vppn_t va);
        tlb_pkg::entry_vec_t m;
        logic g;
        logic a;
        logic v;
        for (int i = 0; i < `TLB_NUM; i++) begin
            g = shadow[i].g;
            a = shadow[i].asid == asid;
            v = shadow[i].vppn == va;
            case (op)
                `INV_ALL0, `INV_ALL1: m[i] = 1'b1;
                `INV_G1:       m[i] = g;
                `INV_G0:       m[i] = !g;
                `INV_ASID:     m[i] = !g && a;
                `INV_ASID_VA:  m[i] = !g && a && v;
                `INV_GASID_VA: m[i] = (g || a) && v;
                default:       m[i] = 1'b0;
            endcase
        end
        return m;
    endfunction

    function automatic res_t lookup_ref(input tlb_pkg::vppn_t va, input logic bit12,
                                        input tlb_pkg::asid_t asid);
        res_t r;
        ent_t x;
        r = '0;
        // scan downward so the lowest match is the one kept
        for (int i = `TLB_NUM - 1; i >= 0; i--) begin
            x = shadow[i];
            if (x.e && x.vppn[18:9] == va[18:9] && (x.ps4m || x.vppn[8:0] == va[8:0])
                    && (x.g || x.asid == asid)) begin
                r.found = 1'b1;
                r.idx = tlb_pkg::idx_t'(i);
            end
        end
        x = shadow[r.idx];
        r.ps = x.ps4m ? `TLB_PS_4M : `TLB_PS_4K;
        r.h = (x.ps4m ? va[8] : bit12) ? x.h1 : x.h0;
        return r;
    endfunction

    // write and/or invalidate strobe with the shadow catching up after the edge
    task automatic apply(input logic do_w, input tlb_pkg::idx_t idx, input ent_t x,
                         input tlb_pkg::ps_t ps, input logic do_inv,
                         input tlb_pkg::inv_op_t op, input tlb_pkg::asid_t asid,
                         input tlb_pkg::vppn_t va);
        tlb_pkg::entry_vec_t clr;
        clr = do_inv ? inv_ref(op, asid, va) : '0;
        @(posedge clk);
        {we, w_index, w_ps} <= {do_w, idx, ps};
        {w_e, w_vppn, w_asid, w_g} <= {x.e, x.vppn, x.asid, x.g};
        {w_ppn0, w_plv0, w_mat0, w_d0, w_v0} <= x.h0;
        {w_ppn1, w_plv1, w_mat1, w_d1, w_v1} <= x.h1;
        {invtlb_valid, invtlb_op, invtlb_asid, invtlb_va} <= {do_inv, op, asid, va};
        @(posedge clk);
        we <= 1'b0;
        invtlb_valid <= 1'b0;
        // read port follows the written entry
        if (do_w)
            r_index <= idx;
        if (do_w) begin
            shadow[idx] = x;
            shadow[idx].ps4m = (ps == `TLB_PS_4M);
        end
        for (int i = 0; i < `TLB_NUM; i++)
            if (clr[i]) shadow[i].e = 1'b0;
    endtask

    task automatic fill_table();
        for (int i = 0; i < `TLB_NUM; i++)
            apply(1'b1, tlb_pkg::idx_t'(i), rand_entry(), rand_ps(), 1'b0, '0, '0, '0);
    endtask

    task automatic read_check(input tlb_pkg::idx_t idx, input logic full);
        ent_t x;
        x = shadow[idx];
        @(posedge clk);
        r_index <= idx;
        @(negedge clk);
        check("r_e", 32'(r_e), 32'(x.e));
        if (full) begin
            check("r_vppn", 32'(r_vppn), 32'(x.vppn));
            check("r_ps", 32'(r_ps), x.ps4m ? 32'd21 : 32'd12);
            check("r_asid", 32'(r_asid), 32'(x.asid));
            check("r_g", 32'(r_g), 32'(x.g));
            check("r_ppn0..r_v0", 32'({r_ppn0, r_plv0, r_mat0, r_d0, r_v0}), 32'(x.h0));
            check("r_ppn1..r_v1", 32'({r_ppn1, r_plv1, r_mat1, r_d1, r_v1}), 32'(x.h1));
        end
    endtask

    task automatic query_check();
        tlb_pkg::vppn_t va0, va1;
        tlb_pkg::asid_t as0, as1;
        res_t r0, r1;
        rand_query(va0, as0);
        rand_query(va1, as1);
        @(posedge clk);
        {s0_vppn, s0_asid, s0_va_bit12} <= {va0, as0, 1'($urandom)};
        {s1_vppn, s1_asid, s1_va_bit12} <= {va1, as1, 1'($urandom)};
        @(negedge clk);
        r0 = lookup_ref(s0_vppn, s0_va_bit12, s0_asid);
        r1 = lookup_ref(s1_vppn, s1_va_bit12, s1_asid);
        check("s0_found", 32'(s0_found), 32'(r0.found));
        check("s0_index", 32'(s0_index), 32'(r0.idx));
        check("s0_ps", 32'(s0_ps), 32'(r0.ps));
        check("s0_ppn..s0_v", 32'({s0_ppn, s0_plv, s0_mat, s0_d, s0_v}), 32'(r0.h));
        check("s1_found", 32'(s1_found), 32'(r1.found));
        check("s1_index", 32'(s1_index), 32'(r1.idx));
        check("s1_ps", 32'(s1_ps), 32'(r1.ps));
        check("s1_ppn..s1_v", 32'({s1_ppn, s1_plv, s1_mat, s1_d, s1_v}), 32'(r1.h));
    endtask

    initial begin
        ent_t pick;
        tlb_pkg::idx_t idx;
        tlb_pkg::inv_op_t op;
        void'($urandom(81));
        rst = 1'b1;
        {we, w_index, w_e, w_vppn, w_ps, w_asid, w_g} = '0;
        {w_ppn0, w_plv0, w_mat0, w_d0, w_v0, w_ppn1, w_plv1, w_mat1, w_d1, w_v1} = '0;
        {invtlb_valid, invtlb_op, invtlb_asid, invtlb_va, r_index} = '0;
        {s0_vppn, s0_va_bit12, s0_asid, s1_vppn, s1_va_bit12, s1_asid} = '0;
        shadow = '{default: '0};
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < `TLB_NUM; i++)
            read_check(tlb_pkg::idx_t'(i), 1'b0);
        repeat (4) query_check();
        end_test("reset state");

        fill_table();
        for (int i = 0; i < `TLB_NUM; i++)
            read_check(tlb_pkg::idx_t'(i), 1'b1);
        end_test("write and read back");

        repeat (2) begin
            fill_table();
            repeat (N_LOOK / 2) query_check();
        end
        end_test("random lookups");

        // ops 0 to 6, then one reserved code
        for (int k = 0; k < 8; k++) begin
            op = (k < 7) ? tlb_pkg::inv_op_t'(k) : 5'd9;
            fill_table();
            pick = shadow[tlb_pkg::idx_t'($urandom)];
            apply(1'b0, '0, '0, '0, 1'b1, op, pick.asid, pick.vppn);
            for (int i = 0; i < `TLB_NUM; i++)
                read_check(tlb_pkg::idx_t'(i), 1'b0);
            repeat (N_INV_LOOK) query_check();
        end
        end_test("invalidate ops");

        fill_table();
        repeat (8) begin
            idx = tlb_pkg::idx_t'($urandom);
            pick = shadow[idx];
            op = tlb_pkg::inv_op_t'($urandom % 7);
            apply(1'b1, idx, rand_entry(), rand_ps(), 1'b1, op, pick.asid, pick.vppn);
            read_check(idx, 1'b1);
        end
        end_test("write with invalidate");

        errors += UUT.u_assert.fail_count;
        $display("%0d tests, %0d checks, %0d errors", test_no, checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- tb.f
+incdir+src
src/tlb_pkg.sv
src/tlb_array_if.sv
src/tlb_storage.sv
src/tlb_inv_mask.sv
src/tlb_lookup.sv
src/tlb.sv
test/tlb_assertions.sv
test/tb_tlb.sv
